// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/id_pkg.sv
      - rtl/bypass_if.sv
      - rtl/inst_decoder.sv
      - rtl/regfile.sv
      - rtl/operand_bypass.sv
      - rtl/branch_unit.sv
      - rtl/id_stage.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/tb_id_stage.sv

// ==== build.f ====
+incdir+rtl
rtl/id_pkg.sv
rtl/bypass_if.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/id_stage.sv
dv/tb_id_stage.sv

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage;

    localparam int num_insts = 600;
    localparam int timeout_cycles = 200;
    // r-type funcs in alu_op bit order followed by jr and jalr
    localparam logic [5:0] r_funcs [13] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h27, 6'h25,
                                            6'h26, 6'h00, 6'h02, 6'h03, 6'h08, 6'h09};
    localparam logic [5:0] i_ops [16] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23,
                                          6'h2b, 6'h04, 6'h05, 6'h01, 6'h06, 6'h07, 6'h02, 6'h03};
    // alu_op bit of each immediate alu op by its low opcode bits
    localparam int imm_alu_bit [8] = '{0, 0, 2, 3, 4, 6, 7, 11};

    logic clk = 1'b0;
    logic reset, fs_valid, es_allowin, es_valid, es_data_ok, ms_valid, ms_data_ok, wb_valid;
    logic [`ID_XLEN-1:0] fs_pc, fs_inst, es_data, ms_data, wb_data;
    logic [`ID_XLEN-1:0] ds_pc, ds_rs_value, ds_rt_value, br_target;
    logic [`ID_REG_AW-1:0] es_dest, ms_dest, wb_dest, ds_dest;
    logic [`ID_ALU_OP_W-1:0] ds_alu_op;
    logic [15:0] ds_imm;
    logic ds_allowin, ds_to_es_valid, ds_src1_is_sa, ds_src1_is_pc, ds_src2_is_simm;
    logic ds_src2_is_zimm, ds_src2_is_8, ds_load_op, ds_mem_we, ds_gr_we, br_taken, br_stall;

    // reference state
    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];
    logic held_valid;
    logic [`ID_XLEN-1:0] held_pc, held_inst;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int n_in = 0;
    int n_out = 0;

    always #4 clk = ~clk;

    id_stage i_id_stage (.*);

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // bit 32 set when the matching producer is not ready
    function automatic logic [32:0] operand_ref(input logic [`ID_REG_AW-1:0] addr);
        return (addr == 0) ? 33'd0 :
               (es_valid && es_dest == addr) ? {!es_data_ok, es_data} :
               (ms_valid && ms_dest == addr) ? {!ms_data_ok, ms_data} :
               (wb_valid && wb_dest == addr) ? {1'b0, wb_data} : {1'b0, regs[addr]};
    endfunction

    // ctl packs alu_op, operand selects, load, store, write enable, dest and imm
    task automatic decode_ref(input logic [31:0] w, output logic [40:0] ctl,
                              output logic [7:0] br, output logic use_rs, output logic use_rt);
        logic [11:0] alu;
        logic [4:0] dst;
        logic simm, zimm, link, ld, st, we;
        {alu, br, dst, simm, zimm, link, ld, st, we, use_rs, use_rt} = '0;
        case (w[31:26])
            6'h00: begin
                for (int k = 0; k < 11; k++) begin
                    alu[k] = w[5:0] == r_funcs[k] && (k < 8 ? w[10:6] == 0 : w[25:21] == 0);
                end
                br[7] = w[5:0] == 6'h08 && w[20:6] == 0;
                link = w[5:0] == 6'h09 && w[20:16] == 0 && w[10:6] == 0;
                use_rs = |alu[7:0] || br[7] || link;
                use_rt = |alu;
                we = |alu || link;
                dst = w[15:11];
                br[7] = br[7] | link;
            end
            6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                // lui needs rs == 0
                we = w[31:26] != 6'h0f || w[25:21] == 0;
                alu[imm_alu_bit[w[28:26]]] = we;
                zimm = w[31:26] inside {6'h0c, 6'h0d, 6'h0e};
                simm = we && !zimm;
                use_rs = w[31:26] != 6'h0f;
                dst = w[20:16];
            end
            6'h23, 6'h2b: begin
                alu[0] = 1'b1;
                simm = 1'b1;
                st = w[29];
                ld = !st;
                we = ld;
                use_rs = 1'b1;
                use_rt = st;
                dst = w[20:16];
            end
            6'h04, 6'h05: begin
                br[w[26]] = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            6'h01, 6'h06, 6'h07: begin
                br[2] = w[31:26] == 6'h01 && w[20:16] == 1;
                br[5] = w[31:26] == 6'h01 && w[20:16] == 0;
                br[4] = w[31:26] == 6'h06 && w[20:16] == 0;
                br[3] = w[31:26] == 6'h07 && w[20:16] == 0;
                use_rs = |br;
            end
            6'h02, 6'h03: begin
                br[6] = 1'b1;
                link = w[26];
                we = link;
                dst = 5'd31;
            end
            default: ;
        endcase
        alu[0] = alu[0] | link;
        ctl = {alu, |alu[10:8], link, simm, zimm, link, ld, st, we, we ? dst : 5'd0,
               (we || st || |br) ? w[15:0] : 16'h0};
    endtask

    function automatic logic [31:0] random_inst();
        logic [5:0] code;
        logic [4:0] rs, rt, rd, sa;
        rs = $urandom_range(0, 15);
        rt = $urandom_range(0, 15);
        rd = $urandom_range(0, 15);
        // a bad sa now and then makes an illegal word
        sa = ($urandom_range(0, 7) == 0) ? 5'($urandom) : 5'd0;
        case ($urandom_range(0, 15))
            0, 1, 2, 3, 4, 5: begin
                code = r_funcs[$urandom_range(0, 12)];
                if (code inside {6'h00, 6'h02, 6'h03}) begin
                    return {6'h00, 5'd0, rt, rd, 5'($urandom), code};
                end
                rt = (code inside {6'h08, 6'h09}) ? 5'd0 : rt;
                rd = (code == 6'h08) ? 5'd0 : rd;
                return {6'h00, rs, rt, rd, sa, code};
            end
            14, 15: return $urandom;
            default: begin
                code = i_ops[$urandom_range(0, 15)];
                rt = (code == 6'h01) ? 5'($urandom_range(0, 1)) : rt;
                rt = (code inside {6'h06, 6'h07}) ? 5'd0 : rt;
                rs = (code == 6'h0f) ? 5'd0 : rs;
                return {code, rs, rt, 16'($urandom)};
            end
        endcase
    endfunction

    // one clock of stimulus with a mid-cycle check before the reference moves on
    task automatic run_cycle(input logic valid, input logic [31:0] inst, input logic [31:0] pc,
                             input int wb_reg, output logic accepted);
        logic [40:0] ctl;
        logic [7:0] br;
        logic use_rs, use_rt, stall, cond, allow;
        logic [32:0] rs, rt;
        logic [31:0] seq, tgt;
        @(negedge clk);
        fs_valid = valid;
        fs_inst = inst;
        fs_pc = pc;
        es_allowin = $urandom_range(0, 3) != 0;
        {es_valid, es_data_ok, ms_valid, ms_data_ok} = 4'($urandom);
        es_dest = $urandom_range(0, 11);
        ms_dest = $urandom_range(0, 11);
        {es_data, ms_data, wb_data} = {$urandom, $urandom, $urandom};
        wb_valid = (wb_reg > 0) || $urandom_range(0, 1);
        wb_dest = (wb_reg > 0) ? 5'(wb_reg) : 5'($urandom_range(0, 11));
        #2;
        decode_ref(held_inst, ctl, br, use_rs, use_rt);
        rs = operand_ref(held_inst[25:21]);
        rt = operand_ref(held_inst[20:16]);
        stall = (use_rs && rs[32]) || (use_rt && rt[32]);
        allow = !held_valid || (!stall && es_allowin);
        check_value(ds_to_es_valid, held_valid && !stall, "ds_to_es_valid");
        check_value(ds_allowin, allow, "ds_allowin");
        if (held_valid) begin
            seq = held_pc + 4;
            cond = (br[0] && rs[31:0] == rt[31:0]) || (br[1] && rs[31:0] != rt[31:0])
                || (br[2] && $signed(rs[31:0]) >= 0) || (br[3] && $signed(rs[31:0]) > 0)
                || (br[4] && $signed(rs[31:0]) <= 0) || (br[5] && $signed(rs[31:0]) < 0)
                || br[6] || br[7];
            tgt = br[7] ? rs[31:0] : br[6] ? {seq[31:28], held_inst[25:0], 2'b00}
                : seq + (32'($signed(held_inst[15:0])) <<< 2);
            check_value(ds_pc, held_pc, "held pc");
            check_value({ds_alu_op, ds_src1_is_sa, ds_src1_is_pc, ds_src2_is_simm,
                         ds_src2_is_zimm, ds_src2_is_8, ds_load_op, ds_mem_we, ds_gr_we,
                         ds_dest, ds_imm}, ctl, $sformatf("decode of %h", held_inst));
            check_value(ds_rs_value, rs[31:0], "rs operand");
            check_value(ds_rt_value, rt[31:0], "rt operand");
            check_value({br_taken, br_target}, {cond, tgt}, "branch taken and target");
            check_value(br_stall, |br && stall, "br_stall");
        end else begin
            check_value({br_taken, br_stall}, 2'b00, "branch flags of an empty stage");
        end
        n_in += fs_valid && ds_allowin;
        n_out += ds_to_es_valid && es_allowin;
        if (wb_valid && wb_dest != 0) begin
            regs[wb_dest] = wb_data;
        end
        accepted = allow && valid;
        if (allow) begin
            held_valid = valid;
        end
        if (accepted) begin
            held_inst = inst;
            held_pc = pc;
        end
    endtask

    initial begin
        logic accepted;
        logic [31:0] word;
        logic [31:0] pc;
        int waited;
        void'($urandom(39353));
        reset = 1'b1;
        {fs_valid, es_allowin, es_valid, es_data_ok, ms_valid, ms_data_ok, wb_valid} = '0;
        {fs_pc, fs_inst, es_data, ms_data, wb_data, es_dest, ms_dest, wb_dest} = '0;
        {held_valid, held_pc, held_inst} = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        // known contents for every register
        for (int r = 1; r < `ID_NUM_REGS; r++) begin
            run_cycle(1'b0, '0, '0, r, accepted);
        end
        pc = 32'h0040_0000;
        for (int n = 0; n < num_insts && timeouts == 0; n++) begin
            word = random_inst();
            if ($urandom_range(0, 3) == 0) begin
                run_cycle(1'b0, '0, '0, 0, accepted);
            end
            waited = 0;
            accepted = 1'b0;
            while (!accepted && waited < timeout_cycles) begin
                run_cycle(1'b1, word, pc, 0, accepted);
                waited++;
            end
            if (!accepted) begin
                timeouts++;
                $display("timeout: word %h at pc %h was never accepted", word, pc);
            end
            pc += 4;
        end
        waited = 0;
        while (held_valid && waited < timeout_cycles) begin
            run_cycle(1'b0, '0, '0, 0, accepted);
            waited++;
        end
        if (held_valid) begin
            timeouts++;
            $display("timeout: the last instruction never left the stage");
        end
        check_value(n_in, num_insts, "instructions taken in");
        check_value(n_out, num_insts, "instructions handed on");
        $display("checks %0d, errors %0d, timeouts %0d, in %0d, out %0d",
                 checks, errors, timeouts, n_in, n_out);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

module branch_unit import id_pkg::*; (
    input  logic                   valid,
    input  logic [`ID_XLEN-1:0]    pc,
    input  inst_word_t             inst,
    input  logic [`ID_BR_OP_W-1:0] br_op,
    input  logic [`ID_XLEN-1:0]    rs_value,
    input  logic [`ID_XLEN-1:0]    rt_value,
    input  logic                   stall,
    output logic                   taken,
    output logic [`ID_XLEN-1:0]    target,
    output logic                   br_stall
);

    logic op_beq, op_bne, op_bgez, op_bgtz, op_blez, op_bltz;
    logic op_jdir, op_jreg;
    logic [`ID_XLEN-1:0] seq_pc;
    logic rs_eq_rt;
    logic rs_neg;
    logic rs_zero;
    logic cond;

    assign {op_jreg, op_jdir, op_bltz, op_blez, op_bgtz, op_bgez, op_bne, op_beq} = br_op;

    // address of the delay slot
    assign seq_pc = pc + `ID_XLEN'd4;

    assign rs_eq_rt = rs_value == rt_value;
    assign rs_neg   = rs_value[`ID_XLEN-1];
    assign rs_zero  = rs_value == '0;

    assign cond = (op_beq && rs_eq_rt)
               || (op_bne && !rs_eq_rt)
               || (op_bgez && !rs_neg)
               || (op_bgtz && !rs_neg && !rs_zero)
               || (op_blez && (rs_neg || rs_zero))
               || (op_bltz && rs_neg)
               || op_jdir
               || op_jreg;

    assign taken = valid && cond;

    always_comb begin
        if (op_jreg) begin
            target = rs_value;
        end else if (op_jdir) begin
            target = {seq_pc[`ID_XLEN-1:28], inst.j.index, 2'b00};
        end else begin
            target = seq_pc + {{(`ID_XLEN-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};
        end
    end

    // operands not ready yet, fetch must wait for the outcome
    assign br_stall = valid && (|br_op) && stall;

endmodule

// ==== rtl/bypass_if.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

// pending register write of one later pipeline stage
interface bypass_if;

    logic                  valid;
    logic [`ID_REG_AW-1:0] dest;
    logic [`ID_XLEN-1:0]   data;
    // result already computed this cycle
    logic                  data_ok;

    modport src (
        output valid, dest, data, data_ok
    );

    modport sink (
        input valid, dest, data, data_ok
    );

endinterface

// ==== rtl/id_pkg.sv ====
`include "id_settings.svh"

package id_pkg;

    // register format
    typedef struct packed {
        logic [5:0]            op;
        logic [`ID_REG_AW-1:0] rs;
        logic [`ID_REG_AW-1:0] rt;
        logic [`ID_REG_AW-1:0] rd;
        logic [4:0]            sa;
        logic [5:0]            func;
    } r_fields_t;

    // immediate format
    typedef struct packed {
        logic [5:0]            op;
        logic [`ID_REG_AW-1:0] rs;
        logic [`ID_REG_AW-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    // jump format
    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } j_fields_t;

    // one fetched word, viewed through whichever format applies
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_word_t;

endpackage

// ==== rtl/id_settings.svh ====
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data and pc width
`define ID_XLEN 32

// general register file
`define ID_NUM_REGS 32
`define ID_REG_AW 5

// one-hot alu op: add sub slt sltu and nor or xor sll srl sra lui
`define ID_ALU_OP_W 12

// one-hot branch kind: beq bne bgez bgtz blez bltz jdir jreg
`define ID_BR_OP_W 8

`endif

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage import id_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fs_valid,
    input  logic [`ID_XLEN-1:0]     fs_pc,
    input  logic [`ID_XLEN-1:0]     fs_inst,
    output logic                    ds_allowin,
    input  logic                    es_allowin,
    input  logic                    es_valid,
    input  logic [`ID_REG_AW-1:0]   es_dest,
    input  logic [`ID_XLEN-1:0]     es_data,
    input  logic                    es_data_ok,
    input  logic                    ms_valid,
    input  logic [`ID_REG_AW-1:0]   ms_dest,
    input  logic [`ID_XLEN-1:0]     ms_data,
    input  logic                    ms_data_ok,
    input  logic                    wb_valid,
    input  logic [`ID_REG_AW-1:0]   wb_dest,
    input  logic [`ID_XLEN-1:0]     wb_data,
    output logic                    ds_to_es_valid,
    output logic [`ID_XLEN-1:0]     ds_pc,
    output logic [`ID_ALU_OP_W-1:0] ds_alu_op,
    output logic                    ds_src1_is_sa,
    output logic                    ds_src1_is_pc,
    output logic                    ds_src2_is_simm,
    output logic                    ds_src2_is_zimm,
    output logic                    ds_src2_is_8,
    output logic                    ds_load_op,
    output logic                    ds_mem_we,
    output logic                    ds_gr_we,
    output logic [`ID_REG_AW-1:0]   ds_dest,
    output logic [15:0]             ds_imm,
    output logic [`ID_XLEN-1:0]     ds_rs_value,
    output logic [`ID_XLEN-1:0]     ds_rt_value,
    output logic                    br_taken,
    output logic [`ID_XLEN-1:0]     br_target,
    output logic                    br_stall
);

    logic                   ds_valid;
    inst_word_t             ds_inst;
    logic                   uses_rs;
    logic                   uses_rt;
    logic [`ID_BR_OP_W-1:0] br_op;
    logic                   stall;
    logic [`ID_XLEN-1:0]    rf_rs_data;
    logic [`ID_XLEN-1:0]    rf_rt_data;

    bypass_if es_byp ();
    bypass_if ms_byp ();

    assign es_byp.valid   = es_valid;
    assign es_byp.dest    = es_dest;
    assign es_byp.data    = es_data;
    assign es_byp.data_ok = es_data_ok;
    assign ms_byp.valid   = ms_valid;
    assign ms_byp.dest    = ms_dest;
    assign ms_byp.data    = ms_data;
    assign ms_byp.data_ok = ms_data_ok;

    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    inst_decoder i_decoder (
        .inst         (ds_inst),
        .alu_op       (ds_alu_op),
        .src1_is_sa   (ds_src1_is_sa),
        .src1_is_pc   (ds_src1_is_pc),
        .src2_is_simm (ds_src2_is_simm),
        .src2_is_zimm (ds_src2_is_zimm),
        .src2_is_8    (ds_src2_is_8),
        .load_op      (ds_load_op),
        .mem_we       (ds_mem_we),
        .gr_we        (ds_gr_we),
        .dest         (ds_dest),
        .imm          (ds_imm),
        .uses_rs      (uses_rs),
        .uses_rt      (uses_rt),
        .br_op        (br_op)
    );

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (ds_inst.r.rs),
        .raddr2 (ds_inst.r.rt),
        .rdata1 (rf_rs_data),
        .rdata2 (rf_rt_data),
        .we     (wb_valid),
        .waddr  (wb_dest),
        .wdata  (wb_data)
    );

    operand_bypass i_bypass (
        .rs_addr    (ds_inst.r.rs),
        .rt_addr    (ds_inst.r.rt),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .es         (es_byp),
        .ms         (ms_byp),
        .wb_valid   (wb_valid),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data),
        .rf_rs_data (rf_rs_data),
        .rf_rt_data (rf_rt_data),
        .rs_value   (ds_rs_value),
        .rt_value   (ds_rt_value),
        .stall      (stall)
    );

    branch_unit i_branch (
        .valid    (ds_valid),
        .pc       (ds_pc),
        .inst     (ds_inst),
        .br_op    (br_op),
        .rs_value (ds_rs_value),
        .rt_value (ds_rt_value),
        .stall    (stall),
        .taken    (br_taken),
        .target   (br_target),
        .br_stall (br_stall)
    );

    // an instruction handed on never has its branch outcome pending
    handoff_ready: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid && !br_stall);

    // held instruction survives back-pressure and hazard stalls unchanged
    hold_steady: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin |=> ds_valid && $stable(ds_pc) && $stable(ds_inst));

endmodule

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

module inst_decoder import id_pkg::*; (
    input  inst_word_t              inst,
    output logic [`ID_ALU_OP_W-1:0] alu_op,
    output logic                    src1_is_sa,
    output logic                    src1_is_pc,
    output logic                    src2_is_simm,
    output logic                    src2_is_zimm,
    output logic                    src2_is_8,
    output logic                    load_op,
    output logic                    mem_we,
    output logic                    gr_we,
    output logic [`ID_REG_AW-1:0]   dest,
    output logic [15:0]             imm,
    output logic                    uses_rs,
    output logic                    uses_rt,
    output logic [`ID_BR_OP_W-1:0]  br_op
);

    logic op_special;
    logic sa_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_jr, inst_jalr;
    logic inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_blez, inst_bgtz;
    logic inst_j, inst_jal;
    logic r_alu;
    logic shift;
    logic i_alu;
    logic dst_is_rt;
    logic inst_valid;

    assign op_special = inst.r.op == 6'h00;
    assign sa_zero    = inst.r.sa == '0;

    // three-register forms need sa == 0
    assign inst_addu = op_special && sa_zero && inst.r.func == 6'h21;
    assign inst_subu = op_special && sa_zero && inst.r.func == 6'h23;
    assign inst_slt  = op_special && sa_zero && inst.r.func == 6'h2a;
    assign inst_sltu = op_special && sa_zero && inst.r.func == 6'h2b;
    assign inst_and  = op_special && sa_zero && inst.r.func == 6'h24;
    assign inst_or   = op_special && sa_zero && inst.r.func == 6'h25;
    assign inst_xor  = op_special && sa_zero && inst.r.func == 6'h26;
    assign inst_nor  = op_special && sa_zero && inst.r.func == 6'h27;

    // shift by immediate, rs unused
    assign inst_sll = op_special && inst.r.rs == '0 && inst.r.func == 6'h00;
    assign inst_srl = op_special && inst.r.rs == '0 && inst.r.func == 6'h02;
    assign inst_sra = op_special && inst.r.rs == '0 && inst.r.func == 6'h03;

    assign inst_jr   = op_special && inst.r.rt == '0 && inst.r.rd == '0 && sa_zero
                       && inst.r.func == 6'h08;
    assign inst_jalr = op_special && inst.r.rt == '0 && sa_zero && inst.r.func == 6'h09;

    assign inst_addiu = inst.i.op == 6'h09;
    assign inst_slti  = inst.i.op == 6'h0a;
    assign inst_sltiu = inst.i.op == 6'h0b;
    assign inst_andi  = inst.i.op == 6'h0c;
    assign inst_ori   = inst.i.op == 6'h0d;
    assign inst_xori  = inst.i.op == 6'h0e;
    assign inst_lui   = inst.i.op == 6'h0f && inst.i.rs == '0;
    assign inst_lw    = inst.i.op == 6'h23;
    assign inst_sw    = inst.i.op == 6'h2b;

    assign inst_beq  = inst.i.op == 6'h04;
    assign inst_bne  = inst.i.op == 6'h05;
    // regimm group picks the condition through rt
    assign inst_bgez = inst.i.op == 6'h01 && inst.i.rt == `ID_REG_AW'(1);
    assign inst_bltz = inst.i.op == 6'h01 && inst.i.rt == '0;
    assign inst_blez = inst.i.op == 6'h06 && inst.i.rt == '0;
    assign inst_bgtz = inst.i.op == 6'h07 && inst.i.rt == '0;
    assign inst_j    = inst.i.op == 6'h02;
    assign inst_jal  = inst.i.op == 6'h03;

    assign r_alu = inst_addu | inst_subu | inst_slt | inst_sltu
                 | inst_and | inst_or | inst_xor | inst_nor;
    assign shift = inst_sll | inst_srl | inst_sra;
    assign i_alu = inst_addiu | inst_slti | inst_sltiu
                 | inst_andi | inst_ori | inst_xori | inst_lui;

    assign alu_op = {inst_lui, inst_sra, inst_srl, inst_sll,
                     inst_xor | inst_xori, inst_or | inst_ori, inst_nor,
                     inst_and | inst_andi, inst_sltu | inst_sltiu, inst_slt | inst_slti,
                     inst_subu,
                     inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr};

    assign br_op = {inst_jr | inst_jalr, inst_j | inst_jal,
                    inst_bltz, inst_blez, inst_bgtz, inst_bgez, inst_bne, inst_beq};

    assign src1_is_sa   = shift;
    // link address is pc + 8
    assign src1_is_pc   = inst_jal | inst_jalr;
    assign src2_is_8    = inst_jal | inst_jalr;
    assign src2_is_simm = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_zimm = inst_andi | inst_ori | inst_xori;
    assign load_op      = inst_lw;
    assign mem_we       = inst_sw;

    assign gr_we     = r_alu | shift | inst_jalr | i_alu | inst_lw | inst_jal;
    assign dst_is_rt = i_alu | inst_lw;
    assign dest      = inst_jal  ? {`ID_REG_AW{1'b1}} :
                       dst_is_rt ? inst.i.rt :
                       gr_we     ? inst.r.rd : '0;

    assign uses_rs = r_alu | inst_jr | inst_jalr | (i_alu & ~inst_lui) | inst_lw | inst_sw
                   | inst_beq | inst_bne | inst_bgez | inst_bltz | inst_blez | inst_bgtz;
    assign uses_rt = r_alu | shift | inst_sw | inst_beq | inst_bne;

    // unknown words leave every control low
    assign inst_valid = gr_we | mem_we | (|br_op);
    assign imm        = inst_valid ? inst.i.imm : '0;

    alu_op_onehot: assert final ($isunknown(inst) || $onehot0(alu_op))
        else $error("alu_op not one-hot for %h", inst);
    br_op_onehot: assert final ($isunknown(inst) || $onehot0(br_op))
        else $error("br_op not one-hot for %h", inst);

endmodule

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

module operand_bypass (
    input  logic [`ID_REG_AW-1:0] rs_addr,
    input  logic [`ID_REG_AW-1:0] rt_addr,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    bypass_if.sink                es,
    bypass_if.sink                ms,
    input  logic                  wb_valid,
    input  logic [`ID_REG_AW-1:0] wb_dest,
    input  logic [`ID_XLEN-1:0]   wb_data,
    input  logic [`ID_XLEN-1:0]   rf_rs_data,
    input  logic [`ID_XLEN-1:0]   rf_rt_data,
    output logic [`ID_XLEN-1:0]   rs_value,
    output logic [`ID_XLEN-1:0]   rt_value,
    output logic                  stall
);

    logic [`ID_XLEN:0] rs_pick;
    logic [`ID_XLEN:0] rt_pick;

    // newest matching producer wins, msb set when its result is not ready
    function automatic logic [`ID_XLEN:0] pick(
        input logic [`ID_REG_AW-1:0] addr,
        input logic [`ID_XLEN-1:0]   rf_data
    );
        logic [`ID_XLEN:0] result;
        if (addr == '0) begin
            result = '0;
        end else if (es.valid && es.dest == addr) begin
            result = {!es.data_ok, es.data};
        end else if (ms.valid && ms.dest == addr) begin
            result = {!ms.data_ok, ms.data};
        end else if (wb_valid && wb_dest == addr) begin
            // write lands at the end of this cycle
            result = {1'b0, wb_data};
        end else begin
            result = {1'b0, rf_data};
        end
        return result;
    endfunction

    always_comb begin
        rs_pick = pick(rs_addr, rf_rs_data);
        rt_pick = pick(rt_addr, rf_rt_data);
    end

    assign rs_value = rs_pick[`ID_XLEN-1:0];
    assign rt_value = rt_pick[`ID_XLEN-1:0];

    // only operands the instruction reads can hold it back
    assign stall = (uses_rs && rs_pick[`ID_XLEN]) || (uses_rt && rt_pick[`ID_XLEN]);

    stall_not_r0: assert final (
        $isunknown({stall, rs_addr, rt_addr}) || !stall
        || (uses_rs && rs_addr != '0) || (uses_rt && rt_addr != '0))
        else $error("stall raised with no nonzero source read");

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`include "id_settings.svh"

module regfile (
    input  logic                  clk,
    input  logic [`ID_REG_AW-1:0] raddr1,
    input  logic [`ID_REG_AW-1:0] raddr2,
    output logic [`ID_XLEN-1:0]   rdata1,
    output logic [`ID_XLEN-1:0]   rdata2,
    input  logic                  we,
    input  logic [`ID_REG_AW-1:0] waddr,
    input  logic [`ID_XLEN-1:0]   wdata
);

    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule
